// File: common/poly_pkg.sv
`default_nettype none

package poly_pkg;

  ////////////////////////////////////////////////////////////
  // Polynomial geometry
  ////////////////////////////////////////////////////////////

  // One residue coefficient
  localparam int COEFF_W = 30;

  // Coefficients per polynomial and polynomials held in memory
  localparam int N_COEFF = 64;
  localparam int N_SLOT  = 4;

  localparam int IDX_W  = $clog2(N_COEFF);
  localparam int SLOT_W = $clog2(N_SLOT);

  // Address is slot in the upper bits, coefficient index below
  localparam int ADDR_W    = SLOT_W + IDX_W;
  localparam int MEM_DEPTH = N_SLOT * N_COEFF;

  // Full product of two coefficients before reduction
  localparam int PROD_W = 2 * COEFF_W;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  typedef logic [COEFF_W-1:0] coeff_t;
  typedef logic [SLOT_W-1:0]  slot_t;
  typedef logic [IDX_W-1:0]   idx_t;
  typedef logic [ADDR_W-1:0]  mem_addr_t;
  typedef logic [PROD_W-1:0]  prod_t;

  ////////////////////////////////////////////////////////////
  // Moduli, both odd and below 2^30
  ////////////////////////////////////////////////////////////

  localparam coeff_t MOD_Q0 = 30'd1068564481;
  localparam coeff_t MOD_Q1 = 30'd1068433409;

endpackage

`default_nettype wire

// File: common/proc_pkg.sv
`default_nettype none

package proc_pkg;

  import poly_pkg::*;

  // Engine instruction, code 2'd3 is reserved
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MUL = 2'd2
  } op_e;

  // Engine FSM states
  typedef enum logic [2:0] {
    IDLE,
    RD_A,
    RD_B,
    ISSUE,
    WRITE
  } arith_state_e;

  // Owner tag of an outstanding memory read
  localparam logic OWNER_ENG  = 1'b0;
  localparam logic OWNER_HOST = 1'b1;

  // One memory access, 40 bits
  typedef struct packed {
    logic      valid;
    logic      we;
    mem_addr_t addr;
    coeff_t    wdata;
  } mem_req_t;

  // Read data return, 31 bits
  typedef struct packed {
    logic   rvalid;
    coeff_t rdata;
  } mem_rsp_t;

  // Engine command, 9 bits
  typedef struct packed {
    op_e   op;
    slot_t src_a;
    slot_t src_b;
    slot_t dst;
    logic  modulus_sel;
  } arith_cmd_t;

endpackage

`default_nettype wire

// File: hw/poly_mem.sv
`timescale 1ns/1ps
`default_nettype none

module poly_mem
  import poly_pkg::*, proc_pkg::*;
(
  input  logic     clk,
  input  mem_req_t req,
  output coeff_t   rdata
);

  ////////////////////////////////////////////////////////////
  // Coefficient storage
  ////////////////////////////////////////////////////////////

  // All slots back to back, slot index in the upper address bits
  coeff_t mem [MEM_DEPTH];

  coeff_t rdata_q;

  // Single port, write or read per cycle
  always_ff @(posedge clk) begin
    if (req.valid) begin
      if (req.we) begin
        mem[req.addr] <= req.wdata;
      end else begin
        rdata_q <= mem[req.addr];
      end
    end
  end

  // Read data valid one cycle after the request
  assign rdata = rdata_q;

endmodule

`default_nettype wire

// File: hw/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
  import poly_pkg::*, proc_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  mem_req_t host_req,
  input  mem_req_t eng_req,
  output logic     eng_gnt,
  output mem_req_t mem_req,
  input  coeff_t   mem_rdata,
  output mem_rsp_t host_rsp,
  output mem_rsp_t eng_rsp
);

  logic host_sel;
  logic rd_pend_q;
  logic rd_owner_q;

  ////////////////////////////////////////////////////////////
  // Fixed priority, host first
  ////////////////////////////////////////////////////////////

  assign host_sel = host_req.valid;

  // Engine only wins when the host is silent
  assign eng_gnt = eng_req.valid & ~host_req.valid;

  assign mem_req = host_sel ? host_req : eng_req;

  ////////////////////////////////////////////////////////////
  // Read return routing
  ////////////////////////////////////////////////////////////

  // Who issued the read that completes next cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_pend_q  <= 1'b0;
      rd_owner_q <= OWNER_ENG;
    end else begin
      rd_pend_q  <= mem_req.valid & ~mem_req.we;
      rd_owner_q <= host_sel ? OWNER_HOST : OWNER_ENG;
    end
  end

  // Data goes to both, rvalid only to the owner
  always_comb begin
    host_rsp = '{rvalid: rd_pend_q & (rd_owner_q == OWNER_HOST), rdata: mem_rdata};
    eng_rsp  = '{rvalid: rd_pend_q & (rd_owner_q == OWNER_ENG), rdata: mem_rdata};
  end

endmodule

`default_nettype wire

// File: hw/arith/mod_alu.sv
`timescale 1ns/1ps
`default_nettype none

module mod_alu
  import poly_pkg::*, proc_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   in_valid,
  input  op_e    op,
  input  coeff_t q,
  input  coeff_t a,
  input  coeff_t b,
  output logic   out_valid,
  output coeff_t result
);

  logic   s1_valid_q;
  op_e    s1_op_q;
  coeff_t s1_q_q;
  prod_t  s1_raw_q;
  logic   s1_borrow_q;
  logic   s2_valid_q;
  coeff_t s2_result_q;
  prod_t  mul_rem;
  coeff_t red;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= in_valid;
      s2_valid_q <= s1_valid_q;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage one, raw sum, difference or product
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (in_valid) begin
      s1_op_q     <= op;
      s1_q_q      <= q;
      s1_borrow_q <= (a < b);
      case (op)
        OP_ADD:  s1_raw_q <= prod_t'(a) + prod_t'(b);
        OP_SUB:  s1_raw_q <= prod_t'(a) - prod_t'(b);
        OP_MUL:  s1_raw_q <= prod_t'(a) * prod_t'(b);
        default: s1_raw_q <= '0;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage two, reduce mod q
  ////////////////////////////////////////////////////////////

  always_comb begin
    mul_rem = s1_raw_q % prod_t'(s1_q_q);
    case (s1_op_q)
      // Sum is below 2q, one subtraction is enough
      OP_ADD: begin
        if (s1_raw_q >= prod_t'(s1_q_q)) begin
          red = coeff_t'(s1_raw_q - prod_t'(s1_q_q));
        end else begin
          red = s1_raw_q[COEFF_W-1:0];
        end
      end
      // Wrapped difference plus q lands back in range
      OP_SUB:  red = s1_borrow_q ? coeff_t'(s1_raw_q[COEFF_W-1:0] + s1_q_q)
                                 : s1_raw_q[COEFF_W-1:0];
      OP_MUL:  red = mul_rem[COEFF_W-1:0];
      default: red = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (s1_valid_q) begin
      s2_result_q <= red;
    end
  end

  assign out_valid = s2_valid_q;
  assign result    = s2_result_q;

endmodule

`default_nettype wire

// File: hw/arith/poly_arith_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module poly_arith_ctrl
  import poly_pkg::*, proc_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  input  arith_cmd_t cmd,
  output logic       busy,
  output logic       done,
  output mem_req_t   mem_req,
  input  logic       mem_gnt,
  input  mem_rsp_t   mem_rsp
);

  arith_state_e state_q;
  arith_cmd_t   cmd_q;
  idx_t         idx_q;
  coeff_t       a_q;
  coeff_t       b_q;
  coeff_t       res_q;
  coeff_t       q_sel;
  logic         rd_pend_q;
  logic         res_ready_q;
  logic         done_q;
  logic         last_idx;
  logic         wr_fire;
  logic         alu_in_valid;
  logic         alu_out_valid;
  coeff_t       alu_result;

  assign q_sel        = cmd_q.modulus_sel ? MOD_Q1 : MOD_Q0;
  assign last_idx     = (idx_q == idx_t'(N_COEFF - 1));
  assign alu_in_valid = (state_q == ISSUE);
  assign wr_fire      = (state_q == WRITE) && res_ready_q && mem_gnt;
  assign busy         = (state_q != IDLE);
  assign done         = done_q;

  ////////////////////////////////////////////////////////////
  // Memory request, held until granted
  ////////////////////////////////////////////////////////////

  always_comb begin
    mem_req = '0;
    case (state_q)
      RD_A: begin
        mem_req.valid = ~rd_pend_q;
        mem_req.addr  = {cmd_q.src_a, idx_q};
      end
      RD_B: begin
        mem_req.valid = ~rd_pend_q;
        mem_req.addr  = {cmd_q.src_b, idx_q};
      end
      WRITE: begin
        mem_req.valid = res_ready_q;
        mem_req.we    = 1'b1;
        mem_req.addr  = {cmd_q.dst, idx_q};
        mem_req.wdata = res_q;
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= IDLE;
      idx_q       <= '0;
      rd_pend_q   <= 1'b0;
      res_ready_q <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (start) begin
            idx_q   <= '0;
            state_q <= RD_A;
          end
        end
        // Read granted this cycle, data arrives next cycle
        RD_A, RD_B: begin
          if (mem_gnt) begin
            rd_pend_q <= 1'b1;
          end
          if (mem_rsp.rvalid) begin
            rd_pend_q <= 1'b0;
            state_q   <= (state_q == RD_A) ? RD_B : ISSUE;
          end
        end
        ISSUE: state_q <= WRITE;
        WRITE: begin
          if (alu_out_valid) begin
            res_ready_q <= 1'b1;
          end
          if (wr_fire) begin
            res_ready_q <= 1'b0;
            if (last_idx) begin
              done_q  <= 1'b1;
              state_q <= IDLE;
            end else begin
              idx_q   <= idx_q + 1'b1;
              state_q <= RD_A;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Command and operand capture
  always_ff @(posedge clk) begin
    if ((state_q == IDLE) && start) begin
      cmd_q <= cmd;
    end
    if ((state_q == RD_A) && mem_rsp.rvalid) begin
      a_q <= mem_rsp.rdata;
    end
    if ((state_q == RD_B) && mem_rsp.rvalid) begin
      b_q <= mem_rsp.rdata;
    end
    if (alu_out_valid) begin
      res_q <= alu_result;
    end
  end

  mod_alu i_mod_alu (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (alu_in_valid),
    .op        (cmd_q.op),
    .q         (q_sel),
    .a         (a_q),
    .b         (b_q),
    .out_valid (alu_out_valid),
    .result    (alu_result)
  );

endmodule

`default_nettype wire

// File: hw/poly_processor.sv
`timescale 1ns/1ps
`default_nettype none

module poly_processor
  import poly_pkg::*, proc_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       host_req,
  input  logic       host_we,
  input  mem_addr_t  host_addr,
  input  coeff_t     host_wdata,
  output coeff_t     host_rdata,
  output logic       host_rvalid,
  input  logic       start,
  input  arith_cmd_t cmd,
  output logic       busy,
  output logic       done
);

  mem_req_t host_mem_req;
  mem_rsp_t host_rsp;
  mem_req_t eng_req;
  mem_rsp_t eng_rsp;
  logic     eng_gnt;
  mem_req_t mem_req;
  coeff_t   mem_rdata;

  // Host strobe becomes a one-cycle request
  assign host_mem_req = '{valid: host_req, we: host_we, addr: host_addr, wdata: host_wdata};

  assign host_rdata  = host_rsp.rdata;
  assign host_rvalid = host_rsp.rvalid;

  mem_arbiter i_mem_arbiter (
    .clk       (clk),
    .rst_n     (rst_n),
    .host_req  (host_mem_req),
    .eng_req   (eng_req),
    .eng_gnt   (eng_gnt),
    .mem_req   (mem_req),
    .mem_rdata (mem_rdata),
    .host_rsp  (host_rsp),
    .eng_rsp   (eng_rsp)
  );

  poly_mem i_poly_mem (
    .clk   (clk),
    .req   (mem_req),
    .rdata (mem_rdata)
  );

  poly_arith_ctrl i_poly_arith_ctrl (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .cmd     (cmd),
    .busy    (busy),
    .done    (done),
    .mem_req (eng_req),
    .mem_gnt (eng_gnt),
    .mem_rsp (eng_rsp)
  );

endmodule

`default_nettype wire

// File: verif/poly_processor_checker.sv
`timescale 1ns/1ps
`default_nettype none

module poly_processor_checker (
  input logic clk,
  input logic rst_n,
  input logic host_req,
  input logic host_we,
  input logic host_rvalid,
  input logic busy,
  input logic done,
  input logic eng_gnt
);

  ////////////////////////////////////////////////////////////
  // Engine handshake
  ////////////////////////////////////////////////////////////

  // Done is a single-cycle pulse
  done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else $error("done stayed high for more than one cycle");

  // Busy already dropped when done pulses
  done_not_busy: assert property (@(posedge clk) disable iff (!rst_n) done |-> !busy)
    else $error("busy high while done is high");

  ////////////////////////////////////////////////////////////
  // Arbitration and host read return
  ////////////////////////////////////////////////////////////

  host_first: assert property (@(posedge clk) disable iff (!rst_n) !(host_req && eng_gnt))
    else $error("engine granted while host request is valid");

  rvalid_after_read: assert property (@(posedge clk) disable iff (!rst_n)
    (host_req && !host_we) |=> host_rvalid)
    else $error("host_rvalid missing one cycle after host read");

  // No response without a read strobe in the cycle before
  rvalid_has_read: assert property (@(posedge clk) disable iff (!rst_n)
    host_rvalid |-> $past(host_req && !host_we))
    else $error("host_rvalid without a preceding host read");

endmodule

`default_nettype wire

// File: verif/tb_poly_processor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_poly_processor
  import poly_pkg::*, proc_pkg::*;
();

  localparam logic [31:0] LFSR_SEED = 32'h3d23_32e8;
  localparam int RD_TIMEOUT   = 8;
  localparam int DONE_TIMEOUT = 4000;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       host_req;
  logic       host_we;
  mem_addr_t  host_addr;
  coeff_t     host_wdata;
  coeff_t     host_rdata;
  logic       host_rvalid;
  logic       start;
  arith_cmd_t cmd;
  logic       busy;
  logic       done;

  // Memory contents as the host expects them
  coeff_t      model [MEM_DEPTH];
  coeff_t      predicted [N_COEFF];
  logic [31:0] lfsr_state;

  always #10 clk = ~clk;

  poly_processor i_poly_processor (
    .clk         (clk),
    .rst_n       (rst_n),
    .host_req    (host_req),
    .host_we     (host_we),
    .host_addr   (host_addr),
    .host_wdata  (host_wdata),
    .host_rdata  (host_rdata),
    .host_rvalid (host_rvalid),
    .start       (start),
    .cmd         (cmd),
    .busy        (busy),
    .done        (done)
  );

  bind poly_processor poly_processor_checker i_poly_processor_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .host_req    (host_req),
    .host_we     (host_we),
    .host_rvalid (host_rvalid),
    .busy        (busy),
    .done        (done),
    .eng_gnt     (eng_gnt)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic stop_with_failure();
    $display("Test failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual) begin
      $display("ERR time=%0t signal=%s expected=0x%0h actual=0x%0h",
               $time, name, expected, actual);
      stop_with_failure();
    end
  endtask

  // Taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_coeff(input coeff_t q, output coeff_t c);
    coeff_t raw;
    raw = '0;
    for (int i = 0; i < COEFF_W; i++) begin
      raw = {raw[COEFF_W-2:0], lfsr_state[31]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    c = raw % q;
  endtask

  function automatic mem_addr_t slot_addr(input slot_t s, input int i);
    return {s, idx_t'(i)};
  endfunction

  // Modular result of the instruction in 64-bit arithmetic
  function automatic coeff_t ref_mod_op(input op_e op, input coeff_t a, input coeff_t b,
                                        input coeff_t q);
    longint unsigned wa;
    longint unsigned wb;
    longint unsigned wq;
    longint unsigned r;
    wa = {34'd0, a};
    wb = {34'd0, b};
    wq = {34'd0, q};
    case (op)
      OP_ADD:  r = (wa + wb) % wq;
      OP_SUB:  r = (wa + wq - wb) % wq;
      OP_MUL:  r = (wa * wb) % wq;
      default: r = 0;
    endcase
    return r[COEFF_W-1:0];
  endfunction

  task automatic step_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic host_write(input mem_addr_t addr, input coeff_t data);
    host_req   = 1'b1;
    host_we    = 1'b1;
    host_addr  = addr;
    host_wdata = data;
    @(posedge clk);
    #1;
    host_req = 1'b0;
    host_we  = 1'b0;
    model[addr] = data;
  endtask

  task automatic host_read(input mem_addr_t addr, output coeff_t data);
    int lat;
    host_req  = 1'b1;
    host_we   = 1'b0;
    host_addr = addr;
    lat = 0;
    do begin
      @(posedge clk);
      #1;
      host_req = 1'b0;
      lat++;
      if (lat > RD_TIMEOUT) begin
        $display("Timeout: no host_rvalid for read of address 0x%0h", addr);
        stop_with_failure();
      end
    end while (host_rvalid !== 1'b1);
    check("host_rvalid latency", 1, lat);
    data = host_rdata;
  endtask

  task automatic verify_all_slots();
    coeff_t d;
    for (int a = 0; a < MEM_DEPTH; a++) begin
      host_read(mem_addr_t'(a), d);
      check("host_rdata", model[a], d);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Engine control
  ////////////////////////////////////////////////////////////

  task automatic predict(input arith_cmd_t c);
    coeff_t q;
    q = c.modulus_sel ? MOD_Q1 : MOD_Q0;
    for (int i = 0; i < N_COEFF; i++) begin
      predicted[i] = ref_mod_op(c.op, model[slot_addr(c.src_a, i)],
                                model[slot_addr(c.src_b, i)], q);
    end
  endtask

  task automatic commit(input arith_cmd_t c);
    for (int i = 0; i < N_COEFF; i++) begin
      model[slot_addr(c.dst, i)] = predicted[i];
    end
  endtask

  task automatic pulse_start(input arith_cmd_t c);
    start = 1'b1;
    cmd   = c;
    @(posedge clk);
    #1;
    start = 1'b0;
    check("busy", 1, busy);
  endtask

  task automatic wait_done();
    int cycles;
    cycles = 0;
    while (done !== 1'b1) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > DONE_TIMEOUT) begin
        $display("Timeout: done did not pulse within %0d cycles", DONE_TIMEOUT);
        stop_with_failure();
      end
    end
    check("busy", 0, busy);
  endtask

  // Counts done pulses seen over a quiet window
  task automatic count_done(input int n, output int pulses);
    pulses = 0;
    repeat (n) begin
      @(posedge clk);
      #1;
      if (done === 1'b1) begin
        pulses++;
      end
    end
  endtask

  task automatic run_and_check(input arith_cmd_t c);
    int extra;
    predict(c);
    pulse_start(c);
    wait_done();
    count_done(100, extra);
    check("extra done pulses", 0, extra);
    commit(c);
    verify_all_slots();
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_host_write_read();
    coeff_t v;
    // Below both moduli, so any slot is a legal operand
    for (int a = 0; a < MEM_DEPTH; a++) begin
      rand_coeff(MOD_Q1, v);
      host_write(mem_addr_t'(a), v);
    end
    verify_all_slots();
  endtask

  task automatic test_add();
    run_and_check('{op: OP_ADD, src_a: 2'd0, src_b: 2'd1, dst: 2'd2, modulus_sel: 1'b0});
  endtask

  task automatic test_sub();
    // Force a borrow on the first indices
    for (int i = 0; i < 8; i++) begin
      host_write(slot_addr(2'd0, i), coeff_t'(i));
      host_write(slot_addr(2'd1, i), MOD_Q1 - coeff_t'(i + 1));
    end
    run_and_check('{op: OP_SUB, src_a: 2'd0, src_b: 2'd1, dst: 2'd3, modulus_sel: 1'b1});
  endtask

  task automatic test_mul_in_place();
    run_and_check('{op: OP_MUL, src_a: 2'd3, src_b: 2'd1, dst: 2'd3, modulus_sel: 1'b0});
  endtask

  task automatic test_host_priority();
    arith_cmd_t c;
    int         cycles;
    int         idx;
    int         extra;
    logic       rd_open;
    coeff_t     rd_exp;
    c = '{op: OP_ADD, src_a: 2'd0, src_b: 2'd3, dst: 2'd2, modulus_sel: 1'b0};
    predict(c);
    pulse_start(c);
    cycles  = 0;
    idx     = 0;
    rd_open = 1'b0;
    rd_exp  = '0;
    // Host reads of slot 1 interleaved with the running add
    while (done !== 1'b1) begin
      if (cycles % 3 == 0) begin
        host_req  = 1'b1;
        host_we   = 1'b0;
        host_addr = slot_addr(2'd1, idx);
        rd_exp    = model[slot_addr(2'd1, idx)];
        idx       = (idx + 1) % N_COEFF;
        rd_open   = 1'b1;
      end
      @(posedge clk);
      #1;
      host_req = 1'b0;
      cycles++;
      if (rd_open) begin
        check("host_rvalid", 1, host_rvalid);
        check("host_rdata", rd_exp, host_rdata);
        rd_open = 1'b0;
      end
      if (cycles > DONE_TIMEOUT) begin
        $display("Timeout: done did not pulse during host traffic");
        stop_with_failure();
      end
    end
    check("busy", 0, busy);
    count_done(100, extra);
    check("extra done pulses", 0, extra);
    commit(c);
    verify_all_slots();
  endtask

  task automatic test_start_while_busy();
    arith_cmd_t c1;
    arith_cmd_t c2;
    int         extra;
    c1 = '{op: OP_SUB, src_a: 2'd0, src_b: 2'd1, dst: 2'd3, modulus_sel: 1'b1};
    // Would overwrite slot 1 if it were taken
    c2 = '{op: OP_MUL, src_a: 2'd2, src_b: 2'd2, dst: 2'd1, modulus_sel: 1'b0};
    predict(c1);
    pulse_start(c1);
    step_cycles(5);
    pulse_start(c2);
    wait_done();
    count_done(200, extra);
    check("done pulses", 1, 1 + extra);
    commit(c1);
    verify_all_slots();
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n      = 1'b0;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    start      = 1'b0;
    cmd        = '0;
    lfsr_state = LFSR_SEED;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    step_cycles(2);
    check("busy after reset", 0, busy);
    check("done after reset", 0, done);

    test_host_write_read();
    test_add();
    test_sub();
    test_mul_in_place();
    test_host_priority();
    test_start_while_busy();

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
common/poly_pkg.sv
common/proc_pkg.sv
hw/poly_mem.sv
hw/mem_arbiter.sv
hw/arith/mod_alu.sv
hw/arith/poly_arith_ctrl.sv
hw/poly_processor.sv
verif/poly_processor_checker.sv
verif/tb_poly_processor.sv

// File: run.sh
#!/bin/sh
# Build and run the polynomial coprocessor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_poly_processor -f files.f
if [ $? -ne 0 ]; then
  echo "Verilator compile step returned an error"
  exit 1
fi

./obj_dir/Vtb_poly_processor
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit $status
fi
exit 0
